//--- tb.f
source/link_pkg.sv
source/tag_client.sv
source/link_uplink.sv
source/link_fifo.sv
source/link_downlink.sv
source/chip_link_hub.sv
sim/link_checker.sv
sim/tb_chip_link_hub.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary -j 0
TOP       := tb_chip_link_hub
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_chip_link_hub.sv
// testbench for the link hub; decimation values stay fixed once traffic starts
`timescale 1ns/1ps
`default_nettype none

module tb_chip_link_hub
  import link_pkg::*;
();

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     tag_data;
  logic                     tag_en;
  logic                     core_v = 1'b0;
  logic [link_width_lp-1:0] core_data = '0;
  logic                     core_ready;
  logic                     pad_out_v;
  logic [link_width_lp-1:0] pad_out_data;
  logic                     pad_out_tkn = 1'b0;
  logic                     pad_in_v = 1'b0;
  logic [link_width_lp-1:0] pad_in_data = '0;
  logic                     pad_in_tkn;
  logic                     core_v_out;
  logic [link_width_lp-1:0] core_data_out;
  logic                     core_yumi = 1'b0;

  // config as the tag frames should have set it
  logic                              up_en = 1'b0;
  logic [lg_decimation_width_lp-1:0] up_d = '0;
  logic [lg_decimation_width_lp-1:0] down_d = '0;

  // requests from the sequence, progress from the driver
  int   seed = 91;
  int   out_asked = 0;
  int   out_sent = 0;
  logic out_took = 1'b0;
  int   in_asked = 0;
  int   in_sent = 0;
  int   in_credits = fifo_depth_lp;
  int   deq_done = 0;
  logic deq_took = 1'b0;
  int   rx_words = 0;
  int   tokens_asked = 0;
  int   tokens_given = 0;
  logic auto_tokens = 1'b0;
  int   mismatches;
  int   timeouts = 0;

  always #5 clk = ~clk;

  chip_link_hub i_chip_link_hub
  (
    .core_clk_i     (clk),
    .rst_n_i        (rst_n),
    .tag_data_i     (tag_data),
    .tag_en_i       (tag_en),
    .core_v_i       (core_v),
    .core_data_i    (core_data),
    .core_ready_o   (core_ready),
    .pad_out_v_o    (pad_out_v),
    .pad_out_data_o (pad_out_data),
    .pad_out_tkn_i  (pad_out_tkn),
    .pad_in_v_i     (pad_in_v),
    .pad_in_data_i  (pad_in_data),
    .pad_in_tkn_o   (pad_in_tkn),
    .core_v_o       (core_v_out),
    .core_data_o    (core_data_out),
    .core_yumi_i    (core_yumi)
  );

  link_checker i_link_checker
  (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .up_en_i        (up_en),
    .up_d_i         (up_d),
    .down_d_i       (down_d),
    .core_v_i       (core_v),
    .core_data_i    (core_data),
    .core_ready_i   (core_ready),
    .pad_out_v_i    (pad_out_v),
    .pad_out_data_i (pad_out_data),
    .pad_out_tkn_i  (pad_out_tkn),
    .pad_in_v_i     (pad_in_v),
    .pad_in_data_i  (pad_in_data),
    .pad_in_tkn_i   (pad_in_tkn),
    .deq_v_i        (core_v_out),
    .deq_data_i     (core_data_out),
    .core_yumi_i    (core_yumi),
    .error_count_o  (mismatches)
  );

  ////////////////////
  // core side and remote side
  ////////////////////

  always @(negedge clk)
  begin
    // a word counts once core_ready was high under it
    if (out_took)
      out_sent++;
    if (out_sent < out_asked)
    begin
      if (!core_v || out_took)
        core_data = link_width_lp'($random(seed));
      core_v = 1'b1;
    end
    else
      core_v = 1'b0;
    out_took = core_v && core_ready;

    // remote receiver returns one token per 2^d words
    if (pad_out_v)
      rx_words++;
    pad_out_tkn = 1'b0;
    if (tokens_given < tokens_asked || (auto_tokens && rx_words >= (1 << up_d)))
    begin
      pad_out_tkn = 1'b1;
      rx_words = rx_words - (1 << up_d);
      if (tokens_given < tokens_asked)
        tokens_given++;
    end

    // remote sender spends its credits
    if (pad_in_tkn)
      in_credits = in_credits + (1 << down_d);
    if (in_credits > fifo_depth_lp)
      in_credits = fifo_depth_lp;
    if (deq_took)
      deq_done++;
    pad_in_v = 1'b0;
    if (in_sent < in_asked && in_credits > 0)
    begin
      pad_in_v = 1'b1;
      pad_in_data = link_width_lp'($random(seed));
      in_credits--;
      in_sent++;
    end
    // random gaps in yumi
    core_yumi = rst_n && core_v_out && (($random(seed) & 3) != 0);
    deq_took = core_yumi && core_v_out;
  end

  ////////////////////
  // sequence
  ////////////////////

  // frame is id then payload, lsb first; nbits below 12 cuts it short
  task automatic send_frame(input logic [tag_id_width_lp-1:0] id,
                            input logic [tag_payload_width_lp-1:0] payload,
                            input int nbits);
    logic [tag_id_width_lp+tag_payload_width_lp-1:0] frame;
    frame = {payload, id};
    for (int i = 0; i < nbits; i++)
    begin
      @(negedge clk);
      tag_en = 1'b1;
      tag_data = frame[i];
    end
    @(negedge clk);
    tag_en = 1'b0;
    tag_data = 1'b0;
    @(negedge clk);
    // register loads one cycle after the last bit, only on a full matching frame
    if (nbits == tag_id_width_lp + tag_payload_width_lp && id == tag_uplink_id_lp)
    begin
      up_en = payload[0];
      up_d = payload[2:1];
    end
    if (nbits == tag_id_width_lp + tag_payload_width_lp && id == tag_downlink_id_lp)
      down_d = payload[1:0];
    @(posedge clk);
  endtask

  task automatic wait_idle(input string what);
    int cycles;
    cycles = 0;
    while ((out_sent < out_asked || deq_done < in_asked) && cycles < 2000)
    begin
      @(posedge clk);
      cycles++;
    end
    if (cycles >= 2000)
    begin
      $display("timeout while waiting for %s", what);
      timeouts++;
    end
  endtask

  initial
  begin
    rst_n = 1'b0;
    tag_en = 1'b0;
    tag_data = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    // uplink still off, the held word must stay put
    out_asked = 1;
    repeat (10) @(posedge clk);
    send_frame(tag_downlink_id_lp, 8'h02, 12);
    // enable with remote d = 1
    send_frame(tag_uplink_id_lp, 8'h03, 12);
    out_asked = 8;
    wait_idle("the first eight words");
    // no credits left
    out_asked = 9;
    repeat (8) @(posedge clk);
    tokens_asked = 1;
    out_asked = 10;
    wait_idle("two words after one token");
    auto_tokens = 1'b1;
    out_asked = 30;
    in_asked = 40;
    wait_idle("mixed traffic");
    // foreign id and short frames change nothing
    send_frame(4'd3, 8'h00, 12);
    send_frame(tag_uplink_id_lp, 8'h00, 9);
    send_frame(tag_downlink_id_lp, 8'h00, 10);
    out_asked = 50;
    in_asked = 83;
    wait_idle("traffic after ignored frames");
    repeat (5) @(posedge clk);
    $display("closing: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/link_checker.sv
// passive checker; assumes up_en_i, up_d_i and down_d_i match what the tag frames wrote
`timescale 1ns/1ps
`default_nettype none

module link_checker
  import link_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              up_en_i,
  input  logic [lg_decimation_width_lp-1:0] up_d_i,
  input  logic [lg_decimation_width_lp-1:0] down_d_i,
  input  logic                              core_v_i,
  input  logic [link_width_lp-1:0]          core_data_i,
  input  logic                              core_ready_i,
  input  logic                              pad_out_v_i,
  input  logic [link_width_lp-1:0]          pad_out_data_i,
  input  logic                              pad_out_tkn_i,
  input  logic                              pad_in_v_i,
  input  logic [link_width_lp-1:0]          pad_in_data_i,
  input  logic                              pad_in_tkn_i,
  input  logic                              deq_v_i,
  input  logic [link_width_lp-1:0]          deq_data_i,
  input  logic                              core_yumi_i,
  output int                                error_count_o
);

  logic [link_width_lp-1:0] out_q [$];
  logic [link_width_lp-1:0] in_q [$];
  logic [link_width_lp-1:0] exp_word;
  logic                     exp_ready;
  logic                     taken_prev;
  logic                     tkn_due;
  logic                     in_full;
  int                       credits;
  int                       deq_cnt;
  int                       errors = 0;

  assign error_count_o = errors;

  ////////////////////
  // reference rules
  ////////////////////

  // one token per 2^d dequeues
  function automatic int expected_tokens(input int deqs, input int d);
    return deqs >> d;
  endfunction

  // ready only when enabled and some credit left
  function automatic logic expected_ready(input logic en, input int cr);
    return en && (cr != 0);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
    errors++;
  endtask

  ////////////////////
  // compare
  ////////////////////

  always @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      credits    = fifo_depth_lp;
      deq_cnt    = 0;
      taken_prev = 1'b0;
      tkn_due    = 1'b0;
      out_q.delete();
      in_q.delete();
    end
    else
    begin
      // outbound side
      exp_ready = expected_ready(up_en_i, credits);
      if (core_ready_i !== exp_ready)
        report_mismatch("core_ready_o", 32'(core_ready_i), 32'(exp_ready));
      if (pad_out_v_i !== taken_prev)
        report_mismatch("pad_out_v_o", 32'(pad_out_v_i), 32'(taken_prev));
      // word shows up exactly one cycle after it was taken
      if (taken_prev)
      begin
        exp_word = out_q.pop_front();
        if (pad_out_data_i !== exp_word)
          report_mismatch("pad_out_data_o", 32'(pad_out_data_i), 32'(exp_word));
      end
      taken_prev = core_v_i && exp_ready;
      if (taken_prev)
        out_q.push_back(core_data_i);
      credits = credits - int'(taken_prev) + (pad_out_tkn_i ? (1 << up_d_i) : 0);
      if (credits > fifo_depth_lp)
        credits = fifo_depth_lp;

      // inbound side
      if (deq_v_i !== (in_q.size() != 0))
        report_mismatch("core_v_o", 32'(deq_v_i), 32'(in_q.size() != 0));
      if (pad_in_tkn_i !== tkn_due)
        report_mismatch("pad_in_tkn_o", 32'(pad_in_tkn_i), 32'(tkn_due));
      tkn_due = 1'b0;
      // fullness as seen before this edge's dequeue
      in_full = (in_q.size() >= fifo_depth_lp);
      if (deq_v_i && core_yumi_i && in_q.size() != 0)
      begin
        exp_word = in_q.pop_front();
        if (deq_data_i !== exp_word)
          report_mismatch("core_data_o", 32'(deq_data_i), 32'(exp_word));
        // token due on the cycle after the count crosses a multiple of 2^d
        tkn_due = expected_tokens(deq_cnt + 1, int'(down_d_i))
                > expected_tokens(deq_cnt, int'(down_d_i));
        deq_cnt++;
      end
      // writes into a full buffer are lost
      if (pad_in_v_i && !in_full)
        in_q.push_back(pad_in_data_i);
    end
  end

endmodule

`default_nettype wire

//--- source/chip_link_hub.sv
// single clock link hub; all pads run on core_clk_i with no clock forwarding or output disable
`timescale 1ns/1ps
`default_nettype none

module chip_link_hub
  import link_pkg::*;
(
  input  logic                     core_clk_i,
  input  logic                     rst_n_i,
  input  logic                     tag_data_i,
  input  logic                     tag_en_i,
  input  logic                     core_v_i,
  input  logic [link_width_lp-1:0] core_data_i,
  output logic                     core_ready_o,
  output logic                     pad_out_v_o,
  output logic [link_width_lp-1:0] pad_out_data_o,
  input  logic                     pad_out_tkn_i,
  input  logic                     pad_in_v_i,
  input  logic [link_width_lp-1:0] pad_in_data_i,
  output logic                     pad_in_tkn_o,
  output logic                     core_v_o,
  output logic [link_width_lp-1:0] core_data_o,
  input  logic                     core_yumi_i
);

  ////////////////////
  // tag bus
  ////////////////////

  logic                            tag_data_lo;
  logic [tag_payload_width_lp-1:0] up_config_lo;
  logic [tag_payload_width_lp-1:0] down_config_lo;

  // data only counts while enable is high
  assign tag_data_lo = tag_en_i & tag_data_i;

  tag_client #(.node_id_p(tag_uplink_id_lp)) i_tag_uplink
  (
    .core_clk_i (core_clk_i),
    .rst_n_i    (rst_n_i),
    .tag_data_i (tag_data_lo),
    .tag_en_i   (tag_en_i),
    .config_o   (up_config_lo)
  );

  tag_client #(.node_id_p(tag_downlink_id_lp)) i_tag_downlink
  (
    .core_clk_i (core_clk_i),
    .rst_n_i    (rst_n_i),
    .tag_data_i (tag_data_lo),
    .tag_en_i   (tag_en_i),
    .config_o   (down_config_lo)
  );

  ////////////////////
  // link channels
  ////////////////////

  // uplink config is enable in bit 0 and remote d in bits 2:1
  // downlink config is local d in bits 1:0
  link_uplink i_link_uplink
  (
    .core_clk_i      (core_clk_i),
    .rst_n_i         (rst_n_i),
    .enable_i        (up_config_lo[0]),
    .lg_decimation_i (up_config_lo[lg_decimation_width_lp:1]),
    .core_v_i        (core_v_i),
    .core_data_i     (core_data_i),
    .core_ready_o    (core_ready_o),
    .link_v_o        (pad_out_v_o),
    .link_data_o     (pad_out_data_o),
    .link_token_i    (pad_out_tkn_i)
  );

  // inbound pads feed the receive side directly
  link_downlink i_link_downlink
  (
    .core_clk_i      (core_clk_i),
    .rst_n_i         (rst_n_i),
    .lg_decimation_i (down_config_lo[lg_decimation_width_lp-1:0]),
    .link_v_i        (pad_in_v_i),
    .link_data_i     (pad_in_data_i),
    .link_token_o    (pad_in_tkn_o),
    .core_v_o        (core_v_o),
    .core_data_o     (core_data_o),
    .core_yumi_i     (core_yumi_i)
  );

endmodule

`default_nettype wire

//--- source/link_downlink.sv
// inbound channel; tokens go back once per 2^d dequeues, and d should only change while the link is idle
`timescale 1ns/1ps
`default_nettype none

module link_downlink
  import link_pkg::*;
(
  input  logic                              core_clk_i,
  input  logic                              rst_n_i,
  input  logic [lg_decimation_width_lp-1:0] lg_decimation_i,
  input  logic                              link_v_i,
  input  logic [link_width_lp-1:0]          link_data_i,
  output logic                              link_token_o,
  output logic                              core_v_o,
  output logic [link_width_lp-1:0]          core_data_o,
  input  logic                              core_yumi_i
);

  logic                        fifo_v_lo;
  logic                        deq;
  logic [dec_cnt_width_lp-1:0] deq_cnt_r;
  logic [dec_cnt_width_lp-1:0] deq_last;

  ////////////////////
  // receive buffer
  ////////////////////

  // link words land straight in the fifo on the link_v_i edge
  link_fifo i_link_fifo
  (
    .core_clk_i (core_clk_i),
    .rst_n_i    (rst_n_i),
    .w_v_i      (link_v_i),
    .w_data_i   (link_data_i),
    .r_v_o      (fifo_v_lo),
    .r_data_o   (core_data_o),
    .r_yumi_i   (deq)
  );

  assign core_v_o = fifo_v_lo;

  // yumi without valid is ignored
  assign deq = core_yumi_i & fifo_v_lo;

  ////////////////////
  // token return
  ////////////////////

  // last count value before the wrap
  assign deq_last = dec_cnt_width_lp'((1 << lg_decimation_i) - 1);

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      deq_cnt_r    <= '0;
      link_token_o <= 1'b0;
    end
    else
    begin
      // token is a single cycle pulse
      link_token_o <= 1'b0;
      if (deq)
      begin
        // >= also recovers if d shrank mid count
        if (deq_cnt_r >= deq_last)
        begin
          deq_cnt_r    <= '0;
          link_token_o <= 1'b1;
        end
        else
        begin
          deq_cnt_r <= deq_cnt_r + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/link_fifo.sv
// 8 entry receive buffer; a write while full is silently lost, the sender must respect credits
`timescale 1ns/1ps
`default_nettype none

module link_fifo
  import link_pkg::*;
(
  input  logic                     core_clk_i,
  input  logic                     rst_n_i,
  input  logic                     w_v_i,
  input  logic [link_width_lp-1:0] w_data_i,
  output logic                     r_v_o,
  output logic [link_width_lp-1:0] r_data_o,
  input  logic                     r_yumi_i
);

  logic [link_width_lp-1:0]    mem_r [fifo_depth_lp];
  logic [lg_fifo_depth_lp-1:0] wptr_r, rptr_r;
  logic [lg_fifo_depth_lp:0]   count_r;
  logic                        full;
  logic                        do_write;
  logic                        do_read;

  assign full     = (count_r == (lg_fifo_depth_lp + 1)'(fifo_depth_lp));
  assign do_write = w_v_i & ~full;
  assign do_read  = r_yumi_i & r_v_o;

  // head entry shown as soon as count is nonzero
  assign r_v_o    = (count_r != '0);
  assign r_data_o = mem_r[rptr_r];

  // pointers wrap on their own at depth 8
  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      if (do_write)
        wptr_r <= wptr_r + 1'b1;
      if (do_read)
        rptr_r <= rptr_r + 1'b1;
      count_r <= count_r + (lg_fifo_depth_lp + 1)'(do_write)
                         - (lg_fifo_depth_lp + 1)'(do_read);
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (do_write)
      mem_r[wptr_r] <= w_data_i;
  end

endmodule

`default_nettype wire

//--- source/link_uplink.sv
// outbound channel; credits start at fifo depth and the remote side must return tokens at rate 2^d
`timescale 1ns/1ps
`default_nettype none

module link_uplink
  import link_pkg::*;
(
  input  logic                              core_clk_i,
  input  logic                              rst_n_i,
  input  logic                              enable_i,
  input  logic [lg_decimation_width_lp-1:0] lg_decimation_i,
  input  logic                              core_v_i,
  input  logic [link_width_lp-1:0]          core_data_i,
  output logic                              core_ready_o,
  output logic                              link_v_o,
  output logic [link_width_lp-1:0]          link_data_o,
  input  logic                              link_token_i
);

  logic [credit_width_lp-1:0] credits_r;
  logic [credit_width_lp:0]   token_credits;
  logic [credit_width_lp:0]   credit_sum;
  logic [credit_width_lp:0]   credit_max;
  logic                       take;

  ////////////////////
  // credit counter
  ////////////////////

  // ready is a level, the core holds its word until it sees it
  assign core_ready_o = enable_i & (credits_r != '0);
  assign take         = core_v_i & core_ready_o;

  // one token returns 2^d credits
  assign token_credits = link_token_i
                       ? ((credit_width_lp + 1)'(1) << lg_decimation_i)
                       : '0;

  // one extra bit so token plus count cannot wrap
  assign credit_sum = {1'b0, credits_r} + token_credits - (credit_width_lp + 1)'(take);
  assign credit_max = (credit_width_lp + 1)'(fifo_depth_lp);

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
      credits_r <= credit_width_lp'(fifo_depth_lp);
    else if (credit_sum > credit_max)
      credits_r <= credit_width_lp'(fifo_depth_lp);
    else
      credits_r <= credit_sum[credit_width_lp-1:0];
  end

  ////////////////////
  // link outputs
  ////////////////////

  // valid strobe for one cycle per accepted word
  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
      link_v_o <= 1'b0;
    else
      link_v_o <= take;
  end

  // data only matters under link_v_o
  always_ff @(posedge core_clk_i)
  begin
    if (take)
      link_data_o <= core_data_i;
  end

endmodule

`default_nettype wire

//--- source/tag_client.sv
// serial tag receiver for one node; frames must hold tag_en_i high for all 12 bits, short frames are dropped
`timescale 1ns/1ps
`default_nettype none

module tag_client
  import link_pkg::*;
#(
  parameter logic [tag_id_width_lp-1:0] node_id_p = '0
)
(
  input  logic                            core_clk_i,
  input  logic                            rst_n_i,
  input  logic                            tag_data_i,
  input  logic                            tag_en_i,
  output logic [tag_payload_width_lp-1:0] config_o
);

  tag_state_e state_r, state_n;

  logic [tag_cnt_width_lp-1:0]     bit_cnt_r;
  logic [tag_id_width_lp-1:0]      id_r;
  logic [tag_payload_width_lp-1:0] payload_r;
  logic                            last_id_bit;
  logic                            last_payload_bit;
  logic                            id_match;
  logic                            id_shift;

  assign last_id_bit      = (bit_cnt_r == tag_cnt_width_lp'(tag_id_width_lp - 1));
  assign last_payload_bit = (bit_cnt_r == tag_cnt_width_lp'(tag_payload_width_lp - 1));
  assign id_match         = (id_r == node_id_p);

  // id bits are taken in idle and write too, a new frame may start there
  assign id_shift = tag_en_i & (state_r != tag_payload);

  ////////////////////
  // frame fsm
  ////////////////////

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      tag_idle, tag_write:
        state_n = tag_en_i ? tag_id : tag_idle;
      tag_id:
        if (!tag_en_i)
          state_n = tag_idle;
        else if (last_id_bit)
          state_n = tag_payload;
      tag_payload:
        if (!tag_en_i)
          state_n = tag_idle;
        else if (last_payload_bit)
          state_n = tag_write;
      default:
        state_n = tag_idle;
    endcase
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r   <= tag_idle;
      bit_cnt_r <= '0;
      config_o  <= '0;
    end
    else
    begin
      state_r <= state_n;
      // first id bit arrives with the rising enable
      if (state_r == tag_idle || state_r == tag_write)
        bit_cnt_r <= tag_cnt_width_lp'(1);
      else if (state_r == tag_id && last_id_bit)
        bit_cnt_r <= '0;
      else
        bit_cnt_r <= bit_cnt_r + 1'b1;
      // other nodes' frames pass by untouched
      if (state_r == tag_write && id_match)
        config_o <= payload_r;
    end
  end

  // lsb first, so new bits enter at the top
  always_ff @(posedge core_clk_i)
  begin
    if (id_shift)
      id_r <= {tag_data_i, id_r[tag_id_width_lp-1:1]};
    if (tag_en_i && state_r == tag_payload)
      payload_r <= {tag_data_i, payload_r[tag_payload_width_lp-1:1]};
  end

endmodule

`default_nettype wire

//--- source/link_pkg.sv
// shared link and tag constants; widths are fixed here, so changing fifo depth also changes reset credits
`default_nettype none

package link_pkg;

  ////////////////////
  // link channel
  ////////////////////

  // one link word
  localparam int link_width_lp = 16;

  // receive buffer depth as log2
  localparam int lg_fifo_depth_lp = 3;
  localparam int fifo_depth_lp = 1 << lg_fifo_depth_lp;

  // credit counter must reach fifo_depth_lp itself
  localparam int credit_width_lp = 4;

  // decimation d selects 2^d credits per token
  localparam int lg_decimation_width_lp = 2;

  // dequeue counter wraps at most at 2^3 - 1
  localparam int dec_cnt_width_lp = (1 << lg_decimation_width_lp) - 1;

  ////////////////////
  // tag bus
  ////////////////////

  // frame is id then payload, both lsb first
  localparam int tag_id_width_lp = 4;
  localparam int tag_payload_width_lp = 8;

  // bit counter sized for the longer field
  localparam int tag_cnt_width_lp = $clog2(tag_payload_width_lp);

  // node ids on the shared tag bus
  localparam logic [tag_id_width_lp-1:0] tag_uplink_id_lp = 4'd1;
  localparam logic [tag_id_width_lp-1:0] tag_downlink_id_lp = 4'd2;

  // receiver states
  typedef enum logic [1:0]
  {
    tag_idle,
    tag_id,
    tag_payload,
    tag_write
  } tag_state_e;

endpackage

`default_nettype wire
